//--- design/ddr_bridge_config.svh
`ifndef DDR_BRIDGE_CONFIG_SVH
`define DDR_BRIDGE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// Memory side widths
////////////////////////////////////////////////////////////////////////

// One DDR beat and its byte strobes
`define DDR_DATA_W 512
`define DDR_STRB_W 64

// Request address as seen by the requester
`define DDR_ADDR_W 64

// Controller address field, taken from the request address at bit 3
`define APP_ADDR_W 28
`define APP_ADDR_LSB 3

////////////////////////////////////////////////////////////////////////
// Register bus widths
////////////////////////////////////////////////////////////////////////

`define LITE_ADDR_W 16
`define LITE_DATA_W 32

// Entries per command or data queue
`define CMD_QUEUE_DEPTH 16

`endif

//--- design/ddr_bridge_pkg.sv
`include "ddr_bridge_config.svh"

package ddr_bridge_pkg;

   // Test register offsets
   typedef enum logic [`LITE_ADDR_W-1:0] {
      REG_OPERAND_A = `LITE_ADDR_W'(0),
      REG_OPERAND_B = `LITE_ADDR_W'(4),
      REG_SUM       = `LITE_ADDR_W'(8)
   } reg_offset_e;

   // Controller opcodes
   typedef enum logic [2:0] {
      APP_WRITE        = 3'b000,
      APP_READ         = 3'b001,
      APP_WRITE_MASKED = 3'b011
   } app_cmd_e;

   typedef enum logic {
      SIDE_WRITE = 1'b0,
      SIDE_READ  = 1'b1
   } arb_side_e;

   typedef struct packed {
      logic                    awvalid;
      logic [`LITE_ADDR_W-1:0] awaddr;
      logic                    wvalid;
      logic [`LITE_DATA_W-1:0] wdata;
   } lite_wr_req_t;

   typedef struct packed {
      logic                    arvalid;
      logic [`LITE_ADDR_W-1:0] araddr;
   } lite_rd_req_t;

   typedef struct packed {
      logic [`DDR_ADDR_W-1:0] addr;
      logic [`DDR_DATA_W-1:0] data;
      logic [`DDR_STRB_W-1:0] strb;
   } mem_wr_req_t;

   // Masked set for a partial write
   typedef struct packed {
      logic                   masked;
      logic [`DDR_ADDR_W-1:0] addr;
   } wr_cmd_entry_t;

   // Mask bit set means byte not written
   typedef struct packed {
      logic [`DDR_STRB_W-1:0] mask;
      logic [`DDR_DATA_W-1:0] data;
   } wr_data_entry_t;

   typedef struct packed {
      logic                   en;
      app_cmd_e               cmd;
      logic [`APP_ADDR_W-1:0] addr;
   } app_req_t;

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  logic             s_axi_aclk,
   input  logic             s_axi_aresetn,
   input  logic             push,
   input  logic [WIDTH-1:0] din,
   input  logic             pop,
   output logic [WIDTH-1:0] dout,
   output logic             valid,
   output logic             full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // Overflow and underflow requests are dropped
   assign do_push = push && !full;
   assign do_pop  = pop && valid;

   assign valid = (count != '0);
   assign full  = (count == CNT_W'(DEPTH));

   // Show-ahead: head entry always on dout
   assign dout = mem[rd_ptr];

   always_ff @(posedge s_axi_aclk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- design/test_reg_block.sv
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module test_reg_block (
   input  logic                         s_axi_aclk,
   input  logic                         s_axi_aresetn,
   input  ddr_bridge_pkg::lite_wr_req_t wr_req,
   output logic                         awready,
   output logic                         wready,
   output logic                         bvalid,
   input  logic                         bready,
   output logic [1:0]                   bresp,
   input  ddr_bridge_pkg::lite_rd_req_t rd_req,
   output logic                         arready,
   output logic                         rvalid,
   output logic [`LITE_DATA_W-1:0]      rdata,
   output logic [1:0]                   rresp
);

   import ddr_bridge_pkg::*;

   logic [`LITE_DATA_W-1:0] operand_a;
   logic [`LITE_DATA_W-1:0] operand_b;
   logic [`LITE_DATA_W-1:0] sum_q;
   logic                    w_rdy;
   logic                    wr_fire;

   ////////////////////////////////////////////////////////////////////////
   // Read channel
   ////////////////////////////////////////////////////////////////////////

   assign arready = 1'b1;
   assign rresp   = 2'b00;

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         rvalid <= 1'b0;
      end else begin
         rvalid <= rd_req.arvalid;
      end
   end

   // Unknown offsets read as zero
   always_ff @(posedge s_axi_aclk) begin
      case (rd_req.araddr)
         REG_OPERAND_A: rdata <= operand_a;
         REG_OPERAND_B: rdata <= operand_b;
         REG_SUM:       rdata <= sum_q;
         default:       rdata <= '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////
   // Write channel
   ////////////////////////////////////////////////////////////////////////

   assign awready = w_rdy;
   assign wready  = w_rdy;
   assign bresp   = 2'b00;
   assign wr_fire = w_rdy && wr_req.awvalid && wr_req.wvalid;

   // One-cycle accept pulse, blocked while a response is pending
   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         w_rdy <= 1'b0;
      end else if (w_rdy) begin
         w_rdy <= 1'b0;
      end else if (!bvalid && wr_req.awvalid && wr_req.wvalid) begin
         w_rdy <= 1'b1;
      end
   end

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         bvalid <= 1'b0;
      end else if (bvalid && bready) begin
         bvalid <= 1'b0;
      end else if (wr_fire) begin
         bvalid <= 1'b1;
      end
   end

   // Sum offset is read-only
   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         operand_a <= '0;
         operand_b <= '0;
      end else if (wr_fire) begin
         if (wr_req.awaddr == REG_OPERAND_A) begin
            operand_a <= wr_req.wdata;
         end
         if (wr_req.awaddr == REG_OPERAND_B) begin
            operand_b <= wr_req.wdata;
         end
      end
   end

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         sum_q <= '0;
      end else begin
         sum_q <= operand_a + operand_b;
      end
   end

endmodule

//--- design/mem_cmd_queues.sv
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module mem_cmd_queues (
   input  logic                           s_axi_aclk,
   input  logic                           s_axi_aresetn,
   input  ddr_bridge_pkg::mem_wr_req_t    wr_req,
   input  logic                           mem_wr_valid,
   output logic                           mem_wr_cmd_rdy,
   input  logic                           mem_rd_en,
   input  logic [`DDR_ADDR_W-1:0]         mem_rd_addr,
   output logic                           mem_rd_cmd_rdy,
   output ddr_bridge_pkg::wr_cmd_entry_t  wr_cmd,
   output logic                           wr_cmd_valid,
   input  logic                           wr_cmd_pop,
   output logic [`DDR_ADDR_W-1:0]         rd_addr,
   output logic                           rd_cmd_valid,
   input  logic                           rd_cmd_pop,
   output ddr_bridge_pkg::wr_data_entry_t wr_data,
   output logic                           wr_data_valid,
   input  logic                           wr_data_pop
);

   import ddr_bridge_pkg::*;

   wr_cmd_entry_t  wr_cmd_in;
   wr_data_entry_t wr_data_in;
   logic           wr_cmd_full;
   logic           wr_data_full;
   logic           rd_cmd_full;
   logic           wr_push;
   logic           rd_push;

   assign mem_wr_cmd_rdy = !wr_cmd_full && !wr_data_full;
   assign mem_rd_cmd_rdy = !rd_cmd_full;

   // Zero-strobe writes are accepted but never queued
   assign wr_push = mem_wr_valid && mem_wr_cmd_rdy && (wr_req.strb != '0);
   assign rd_push = mem_rd_en && mem_rd_cmd_rdy;

   assign wr_cmd_in.masked = (wr_req.strb != '1);
   assign wr_cmd_in.addr   = wr_req.addr;
   assign wr_data_in.mask  = ~wr_req.strb;
   assign wr_data_in.data  = wr_req.data;

   // Command and data queues share one push, so entries stay paired
   sync_fifo #(.WIDTH($bits(wr_cmd_entry_t)), .DEPTH(`CMD_QUEUE_DEPTH)) u_wr_cmd_fifo (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .push          (wr_push),
      .din           (wr_cmd_in),
      .pop           (wr_cmd_pop),
      .dout          (wr_cmd),
      .valid         (wr_cmd_valid),
      .full          (wr_cmd_full)
   );

   sync_fifo #(.WIDTH($bits(wr_data_entry_t)), .DEPTH(`CMD_QUEUE_DEPTH)) u_wr_data_fifo (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .push          (wr_push),
      .din           (wr_data_in),
      .pop           (wr_data_pop),
      .dout          (wr_data),
      .valid         (wr_data_valid),
      .full          (wr_data_full)
   );

   sync_fifo #(.WIDTH(`DDR_ADDR_W), .DEPTH(`CMD_QUEUE_DEPTH)) u_rd_cmd_fifo (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .push          (rd_push),
      .din           (mem_rd_addr),
      .pop           (rd_cmd_pop),
      .dout          (rd_addr),
      .valid         (rd_cmd_valid),
      .full          (rd_cmd_full)
   );

endmodule

//--- design/mem_cmd_arbiter.sv
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module mem_cmd_arbiter (
   input  logic                          s_axi_aclk,
   input  logic                          s_axi_aresetn,
   input  ddr_bridge_pkg::wr_cmd_entry_t wr_cmd,
   input  logic                          wr_cmd_valid,
   output logic                          wr_cmd_pop,
   input  logic [`DDR_ADDR_W-1:0]        rd_addr,
   input  logic                          rd_cmd_valid,
   output logic                          rd_cmd_pop,
   output ddr_bridge_pkg::app_req_t      app_req,
   input  logic                          app_rdy
);

   import ddr_bridge_pkg::*;

   arb_side_e side_q;

   ////////////////////////////////////////////////////////////////////////
   // Ping-pong side select
   ////////////////////////////////////////////////////////////////////////

   // Stay on a side while it has work, otherwise hand over
   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         side_q <= SIDE_WRITE;
      end else begin
         case (side_q)
            SIDE_WRITE: begin
               if (!wr_cmd_valid) begin
                  side_q <= SIDE_READ;
               end
            end
            SIDE_READ: begin
               if (!rd_cmd_valid) begin
                  side_q <= SIDE_WRITE;
               end
            end
            default: side_q <= SIDE_WRITE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Command mux
   ////////////////////////////////////////////////////////////////////////

   always_comb begin
      if (side_q == SIDE_READ) begin
         app_req.en   = rd_cmd_valid;
         app_req.cmd  = APP_READ;
         app_req.addr = rd_addr[`APP_ADDR_LSB +: `APP_ADDR_W];
      end else begin
         app_req.en   = wr_cmd_valid;
         app_req.cmd  = wr_cmd.masked ? APP_WRITE_MASKED : APP_WRITE;
         app_req.addr = wr_cmd.addr[`APP_ADDR_LSB +: `APP_ADDR_W];
      end
   end

   // Head leaves its queue once the controller takes it
   assign wr_cmd_pop = (side_q == SIDE_WRITE) && wr_cmd_valid && app_rdy;
   assign rd_cmd_pop = (side_q == SIDE_READ) && rd_cmd_valid && app_rdy;

endmodule

//--- design/ddr_bridge_top.sv
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module ddr_bridge_top (
   input  logic                          s_axi_aclk,
   input  logic                          s_axi_aresetn,
   // Test register bus
   input  ddr_bridge_pkg::lite_wr_req_t  lite_wr_req,
   output logic                          awready,
   output logic                          wready,
   output logic                          bvalid,
   input  logic                          bready,
   output logic [1:0]                    bresp,
   input  ddr_bridge_pkg::lite_rd_req_t  lite_rd_req,
   output logic                          arready,
   output logic                          rvalid,
   output logic [`LITE_DATA_W-1:0]       rdata,
   output logic [1:0]                    rresp,
   // Memory request port
   input  ddr_bridge_pkg::mem_wr_req_t   mem_wr_req,
   input  logic                          mem_wr_valid,
   output logic                          mem_wr_cmd_rdy,
   input  logic                          mem_rd_en,
   input  logic [`DDR_ADDR_W-1:0]        mem_rd_addr,
   output logic                          mem_rd_cmd_rdy,
   // DDR controller application port
   output ddr_bridge_pkg::app_req_t      app_req,
   input  logic                          app_rdy,
   output logic [`DDR_DATA_W-1:0]        app_wdf_data,
   output logic [`DDR_STRB_W-1:0]        app_wdf_mask,
   output logic                          app_wdf_wren,
   input  logic                          app_wdf_rdy
);

   import ddr_bridge_pkg::*;

   wr_cmd_entry_t          wr_cmd;
   logic                   wr_cmd_valid;
   logic                   wr_cmd_pop;
   logic [`DDR_ADDR_W-1:0] rd_addr;
   logic                   rd_cmd_valid;
   logic                   rd_cmd_pop;
   wr_data_entry_t         wr_data;

   assign app_wdf_data = wr_data.data;
   assign app_wdf_mask = wr_data.mask;

   test_reg_block u_test_reg_block (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr_req        (lite_wr_req),
      .awready       (awready),
      .wready        (wready),
      .bvalid        (bvalid),
      .bready        (bready),
      .bresp         (bresp),
      .rd_req        (lite_rd_req),
      .arready       (arready),
      .rvalid        (rvalid),
      .rdata         (rdata),
      .rresp         (rresp)
   );

   // Data beats go to the controller without passing the arbiter
   mem_cmd_queues u_mem_cmd_queues (
      .s_axi_aclk     (s_axi_aclk),
      .s_axi_aresetn  (s_axi_aresetn),
      .wr_req         (mem_wr_req),
      .mem_wr_valid   (mem_wr_valid),
      .mem_wr_cmd_rdy (mem_wr_cmd_rdy),
      .mem_rd_en      (mem_rd_en),
      .mem_rd_addr    (mem_rd_addr),
      .mem_rd_cmd_rdy (mem_rd_cmd_rdy),
      .wr_cmd         (wr_cmd),
      .wr_cmd_valid   (wr_cmd_valid),
      .wr_cmd_pop     (wr_cmd_pop),
      .rd_addr        (rd_addr),
      .rd_cmd_valid   (rd_cmd_valid),
      .rd_cmd_pop     (rd_cmd_pop),
      .wr_data        (wr_data),
      .wr_data_valid  (app_wdf_wren),
      .wr_data_pop    (app_wdf_rdy)
   );

   mem_cmd_arbiter u_mem_cmd_arbiter (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr_cmd        (wr_cmd),
      .wr_cmd_valid  (wr_cmd_valid),
      .wr_cmd_pop    (wr_cmd_pop),
      .rd_addr       (rd_addr),
      .rd_cmd_valid  (rd_cmd_valid),
      .rd_cmd_pop    (rd_cmd_pop),
      .app_req       (app_req),
      .app_rdy       (app_rdy)
   );

endmodule

//--- bench/ddr_bridge_props.sv
`timescale 1ns/1ps

module ddr_bridge_props (
   input logic                         s_axi_aclk,
   input logic                         s_axi_aresetn,
   input ddr_bridge_pkg::lite_rd_req_t lite_rd_req,
   input logic                         awready,
   input logic                         bvalid,
   input logic                         bready,
   input logic                         rvalid,
   input ddr_bridge_pkg::app_req_t     app_req,
   input logic                         app_rdy
);

   ////////////////////////////////////////////////////////////////////////
   // Register bus
   ////////////////////////////////////////////////////////////////////////

   a_rvalid_follows: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      lite_rd_req.arvalid |=> rvalid)
      else $error("rvalid did not follow arvalid");

   a_rvalid_idle: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      !lite_rd_req.arvalid |=> !rvalid)
      else $error("rvalid without arvalid");

   a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   // Accept pulse is exactly one cycle
   a_awready_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      awready |=> !awready)
      else $error("awready high for more than one cycle");

   ////////////////////////////////////////////////////////////////////////
   // Controller port
   ////////////////////////////////////////////////////////////////////////

   a_app_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      app_req.en && !app_rdy |=> $stable(app_req))
      else $error("app command changed while stalled");

endmodule

bind ddr_bridge_top ddr_bridge_props u_ddr_bridge_props (.*);

//--- bench/ddr_bridge_tb.sv
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module ddr_bridge_tb;

   import ddr_bridge_pkg::*;

   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 2000;
   localparam int WAIT_LIMIT      = 200;
   localparam int CHK_W           = 640;
   localparam int CMD_W           = 3 + `APP_ADDR_W;
   localparam int BEAT_W          = `DDR_STRB_W + `DDR_DATA_W;

   logic                    s_axi_aclk;
   logic                    s_axi_aresetn;
   lite_wr_req_t            lite_wr_req;
   logic                    awready;
   logic                    wready;
   logic                    bvalid;
   logic                    bready;
   logic [1:0]              bresp;
   lite_rd_req_t            lite_rd_req;
   logic                    arready;
   logic                    rvalid;
   logic [`LITE_DATA_W-1:0] rdata;
   logic [1:0]              rresp;
   mem_wr_req_t             mem_wr_req;
   logic                    mem_wr_valid;
   logic                    mem_wr_cmd_rdy;
   logic                    mem_rd_en;
   logic [`DDR_ADDR_W-1:0]  mem_rd_addr;
   logic                    mem_rd_cmd_rdy;
   app_req_t                app_req;
   logic                    app_rdy;
   logic [`DDR_DATA_W-1:0]  app_wdf_data;
   logic [`DDR_STRB_W-1:0]  app_wdf_mask;
   logic                    app_wdf_wren;
   logic                    app_wdf_rdy;

   logic [31:0]             lcg_state;

   // Expected and observed controller traffic, {opcode, address} and {mask, data}
   logic [CMD_W-1:0]        wr_exp[$];
   logic [CMD_W-1:0]        rd_exp[$];
   logic [BEAT_W-1:0]       beat_exp[$];
   logic [CMD_W-1:0]        cmd_seen[$];
   logic [BEAT_W-1:0]       beat_seen[$];

   ddr_bridge_top u_ddr_bridge_top (.*);

   initial begin
      s_axi_aclk = 1'b0;
      forever #50 s_axi_aclk = ~s_axi_aclk;
   end

   initial begin
      repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge s_axi_aclk);
      abort_run("watchdog expired before all tests finished");
   end

   // Transfers complete on the edge after the sample
   always @(negedge s_axi_aclk) begin
      if (s_axi_aresetn && app_req.en && app_rdy) begin
         cmd_seen.push_back({app_req.cmd, app_req.addr});
      end
      if (s_axi_aresetn && app_wdf_wren && app_wdf_rdy) begin
         beat_seen.push_back({app_wdf_mask, app_wdf_data});
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input logic [CHK_W-1:0] actual,
                              input logic [CHK_W-1:0] expected, input string what);
      if (actual !== expected) begin
         abort_run($sformatf("mismatch at time %0t: %s, got %0h, expected %0h",
                             $time, what, actual, expected));
      end
   endtask

   task automatic step_wait(inout int count, input string what);
      @(negedge s_axi_aclk);
      count++;
      if (count > WAIT_LIMIT) begin
         abort_run({"timed out waiting for ", what});
      end
   endtask

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [63:0] pick_addr();
      return {next_rand(), next_rand()};
   endfunction

   function automatic logic [`DDR_DATA_W-1:0] fill_beat();
      logic [`DDR_DATA_W-1:0] beat;
      for (int i = 0; i < `DDR_DATA_W / 32; i++) begin
         beat[i*32 +: 32] = next_rand();
      end
      return beat;
   endfunction

   task automatic write_register(input logic [`LITE_ADDR_W-1:0] addr,
                                 input logic [`LITE_DATA_W-1:0] data);
      int n;
      @(posedge s_axi_aclk);
      lite_wr_req.awvalid <= 1'b1;
      lite_wr_req.awaddr  <= addr;
      lite_wr_req.wvalid  <= 1'b1;
      lite_wr_req.wdata   <= data;
      n = 0;
      @(negedge s_axi_aclk);
      while (!awready) begin
         step_wait(n, "awready pulse");
      end
      check_value(CHK_W'(wready), CHK_W'(1'b1), "wready with awready");
      @(posedge s_axi_aclk);
      lite_wr_req <= '0;
      n = 0;
      @(negedge s_axi_aclk);
      while (!bvalid) begin
         step_wait(n, "bvalid");
      end
      check_value(CHK_W'(bresp), '0, "bresp");
      @(posedge s_axi_aclk);
      bready <= 1'b1;
      @(posedge s_axi_aclk);
      bready <= 1'b0;
   endtask

   task automatic read_register(input logic [`LITE_ADDR_W-1:0] addr,
                                output logic [`LITE_DATA_W-1:0] data);
      int n;
      @(posedge s_axi_aclk);
      lite_rd_req.arvalid <= 1'b1;
      lite_rd_req.araddr  <= addr;
      @(posedge s_axi_aclk);
      lite_rd_req.arvalid <= 1'b0;
      n = 0;
      @(negedge s_axi_aclk);
      while (!rvalid) begin
         step_wait(n, "rvalid");
      end
      check_value(CHK_W'(rresp), '0, "rresp");
      data = rdata;
   endtask

   // Zero strobes give no entry, partial strobes a masked write
   task automatic record_write(input logic [63:0] addr, input logic [`DDR_DATA_W-1:0] data,
                               input logic [`DDR_STRB_W-1:0] strb);
      logic [2:0] op;
      if (strb != '0) begin
         op = (strb == '1) ? 3'(APP_WRITE) : 3'(APP_WRITE_MASKED);
         wr_exp.push_back({op, addr[`APP_ADDR_LSB +: `APP_ADDR_W]});
         beat_exp.push_back({~strb, data});
      end
   endtask

   task automatic send_write(input logic [63:0] addr, input logic [`DDR_DATA_W-1:0] data,
                             input logic [`DDR_STRB_W-1:0] strb);
      int n;
      @(posedge s_axi_aclk);
      mem_wr_req.addr <= addr;
      mem_wr_req.data <= data;
      mem_wr_req.strb <= strb;
      mem_wr_valid    <= 1'b1;
      n = 0;
      @(negedge s_axi_aclk);
      while (!mem_wr_cmd_rdy) begin
         step_wait(n, "mem_wr_cmd_rdy");
      end
      record_write(addr, data, strb);
      @(posedge s_axi_aclk);
      mem_wr_valid <= 1'b0;
   endtask

   task automatic send_read(input logic [63:0] addr);
      int n;
      @(posedge s_axi_aclk);
      mem_rd_addr <= addr;
      mem_rd_en   <= 1'b1;
      n = 0;
      @(negedge s_axi_aclk);
      while (!mem_rd_cmd_rdy) begin
         step_wait(n, "mem_rd_cmd_rdy");
      end
      rd_exp.push_back({3'(APP_READ), addr[`APP_ADDR_LSB +: `APP_ADDR_W]});
      @(posedge s_axi_aclk);
      mem_rd_en <= 1'b0;
   endtask

   // The class seen first must drain completely before the other one
   task automatic drain_and_compare(input string what);
      logic [CMD_W-1:0] order[$];
      int               n;
      int               total;
      logic             rd_first;
      total = wr_exp.size() + rd_exp.size();
      n = 0;
      @(negedge s_axi_aclk);
      while (cmd_seen.size() < total || beat_seen.size() < beat_exp.size()) begin
         step_wait(n, {what, " traffic"});
      end
      repeat (4) @(negedge s_axi_aclk);
      check_value(CHK_W'(cmd_seen.size()), CHK_W'(total), {what, ": command count"});
      check_value(CHK_W'(beat_seen.size()), CHK_W'(beat_exp.size()), {what, ": beat count"});
      rd_first = 1'b0;
      if (total > 0) begin
         rd_first = (cmd_seen[0][CMD_W-1 -: 3] == 3'(APP_READ));
      end
      if (rd_first) begin
         foreach (rd_exp[i]) begin
            order.push_back(rd_exp[i]);
         end
         foreach (wr_exp[i]) begin
            order.push_back(wr_exp[i]);
         end
      end else begin
         foreach (wr_exp[i]) begin
            order.push_back(wr_exp[i]);
         end
         foreach (rd_exp[i]) begin
            order.push_back(rd_exp[i]);
         end
      end
      foreach (order[i]) begin
         check_value(CHK_W'(cmd_seen[i]), CHK_W'(order[i]),
                     $sformatf("%s: command %0d", what, i));
      end
      foreach (beat_exp[i]) begin
         check_value(CHK_W'(beat_seen[i]), CHK_W'(beat_exp[i]),
                     $sformatf("%s: data beat %0d", what, i));
      end
      wr_exp.delete();
      rd_exp.delete();
      beat_exp.delete();
      cmd_seen.delete();
      beat_seen.delete();
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////

   task automatic reset_values();
      logic [`LITE_DATA_W-1:0] data;
      @(negedge s_axi_aclk);
      check_value(CHK_W'(awready), '0, "awready after reset");
      check_value(CHK_W'(wready), '0, "wready after reset");
      check_value(CHK_W'(bvalid), '0, "bvalid after reset");
      check_value(CHK_W'(rvalid), '0, "rvalid after reset");
      check_value(CHK_W'(app_req.en), '0, "app_en after reset");
      check_value(CHK_W'(app_wdf_wren), '0, "app_wdf_wren after reset");
      check_value(CHK_W'(arready), CHK_W'(1'b1), "arready after reset");
      check_value(CHK_W'(mem_wr_cmd_rdy), CHK_W'(1'b1), "mem_wr_cmd_rdy with empty queues");
      check_value(CHK_W'(mem_rd_cmd_rdy), CHK_W'(1'b1), "mem_rd_cmd_rdy with empty queue");
      for (int i = 0; i < 3; i++) begin
         read_register(`LITE_ADDR_W'(i * 4), data);
         check_value(CHK_W'(data), '0, $sformatf("register at offset %0d after reset", i * 4));
      end
   endtask

   task automatic register_access();
      logic [`LITE_DATA_W-1:0] a;
      logic [`LITE_DATA_W-1:0] b;
      logic [`LITE_DATA_W-1:0] sum;
      logic [`LITE_DATA_W-1:0] data;
      a = next_rand();
      b = next_rand();
      sum = a + b;
      write_register(16'h0, a);
      write_register(16'h4, b);
      read_register(16'h0, data);
      check_value(CHK_W'(data), CHK_W'(a), "operand A readback");
      read_register(16'h4, data);
      check_value(CHK_W'(data), CHK_W'(b), "operand B readback");
      read_register(16'h8, data);
      check_value(CHK_W'(data), CHK_W'(sum), "sum register");
      // Sum offset ignores writes
      write_register(16'h8, next_rand());
      read_register(16'h8, data);
      check_value(CHK_W'(data), CHK_W'(sum), "sum after write to offset 8");
      read_register(16'h0, data);
      check_value(CHK_W'(data), CHK_W'(a), "operand A after write to offset 8");
      read_register(16'hC, data);
      check_value(CHK_W'(data), '0, "unmapped offset 12");
   endtask

   task automatic write_commands();
      logic [`DDR_STRB_W-1:0] partial;
      partial = (pick_addr() | 64'd2) & ~64'd1;
      @(posedge s_axi_aclk);
      app_rdy     <= 1'b1;
      app_wdf_rdy <= 1'b1;
      send_write(pick_addr(), fill_beat(), '1);
      send_write(pick_addr(), fill_beat(), partial);
      send_write(pick_addr(), fill_beat(), '0);
      send_write(pick_addr(), fill_beat(), '1);
      drain_and_compare("write commands");
   endtask

   task automatic read_commands();
      for (int i = 0; i < 4; i++) begin
         send_read(pick_addr());
      end
      drain_and_compare("read commands");
   endtask

   task automatic arbitration_order();
      @(posedge s_axi_aclk);
      app_rdy <= 1'b0;
      for (int i = 0; i < 3; i++) begin
         send_write(pick_addr(), fill_beat(), '1);
      end
      for (int i = 0; i < 3; i++) begin
         send_read(pick_addr());
      end
      @(posedge s_axi_aclk);
      app_rdy <= 1'b1;
      drain_and_compare("arbitration");
   endtask

   task automatic back_pressure();
      logic [63:0]            addr;
      logic [`DDR_DATA_W-1:0] data;
      int                     accepted;
      logic                   stop;
      @(posedge s_axi_aclk);
      app_rdy     <= 1'b0;
      app_wdf_rdy <= 1'b0;
      accepted = 0;
      stop = 1'b0;
      addr = pick_addr();
      data = fill_beat();
      @(posedge s_axi_aclk);
      mem_wr_req.addr <= addr;
      mem_wr_req.data <= data;
      mem_wr_req.strb <= '1;
      mem_wr_valid    <= 1'b1;
      while (!stop) begin
         @(negedge s_axi_aclk);
         if (!mem_wr_cmd_rdy) begin
            stop = 1'b1;
         end else begin
            record_write(addr, data, '1);
            accepted++;
            if (accepted > `CMD_QUEUE_DEPTH + 4) begin
               abort_run("mem_wr_cmd_rdy never dropped while the queues filled");
            end
            addr = pick_addr();
            data = fill_beat();
            @(posedge s_axi_aclk);
            mem_wr_req.addr <= addr;
            mem_wr_req.data <= data;
         end
      end
      @(posedge s_axi_aclk);
      mem_wr_valid <= 1'b0;
      check_value(CHK_W'(accepted), CHK_W'(`CMD_QUEUE_DEPTH), "writes accepted before full");
      repeat (3) @(negedge s_axi_aclk);
      check_value(CHK_W'(app_wdf_wren), CHK_W'(1'b1), "app_wdf_wren while stalled");
      check_value(CHK_W'({app_wdf_mask, app_wdf_data}), CHK_W'(beat_exp[0]),
                  "first beat held while stalled");
      @(posedge s_axi_aclk);
      app_rdy     <= 1'b1;
      app_wdf_rdy <= 1'b1;
      drain_and_compare("back-pressure");
   endtask

   initial begin
      lcg_state      = 32'd70708;
      s_axi_aresetn  = 1'b0;
      lite_wr_req    = '0;
      lite_rd_req    = '0;
      bready         = 1'b0;
      mem_wr_req     = '0;
      mem_wr_valid   = 1'b0;
      mem_rd_en      = 1'b0;
      mem_rd_addr    = '0;
      app_rdy        = 1'b0;
      app_wdf_rdy    = 1'b0;
      repeat (8) @(posedge s_axi_aclk);
      s_axi_aresetn <= 1'b1;
      @(posedge s_axi_aclk);
      reset_values();
      register_access();
      write_commands();
      read_commands();
      arbitration_order();
      back_pressure();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+design
design/ddr_bridge_pkg.sv
design/sync_fifo.sv
design/test_reg_block.sv
design/mem_cmd_queues.sv
design/mem_cmd_arbiter.sv
design/ddr_bridge_top.sv
bench/ddr_bridge_props.sv
bench/ddr_bridge_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = ddr_bridge_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
